// ==== Makefile ====
VERILATOR := verilator
TOP       := fetch_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := No errors
LINTFLAGS := --lint-only --timing --assert
SIMFLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sources.f ====
verilog/fetch_pkg.sv
verilog/fetch_pc.sv
verilog/icache.sv
verilog/fetch_top.sv
tests/axi_rom_model.sv
tests/fetch_tb.sv

// ==== tests/axi_rom_model.sv ====
module axi_rom_model #(
    parameter logic [fetch_pkg::id_w-1:0] axi_id = '0
) (
    input  logic                         clk,
    input  logic                         reset,

    input  fetch_pkg::axi_ar_t           ar,
    input  logic                         arvalid,
    output logic                         arready,
    output fetch_pkg::axi_r_t            r,
    output logic                         rvalid,
    input  logic                         rready,

    input  logic                         fetch_valid,   // watched to find the missed address
    input  logic [fetch_pkg::addr_w-1:0] fetch_pc,

    output int                           errors,
    output int                           bursts,
    output int                           beats
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    localparam int line_lsb = line_words_log + word_bytes_log;

    logic [addr_w-1:0]         miss_addr;
    logic [addr_w-1:line_lsb]  burst_line;
    logic [addr_w-1:line_lsb]  prev_line;
    logic                      prev_known;
    logic [2:0]                offset;      // first word of the burst
    logic [2:0]                beat;
    logic                      busy;
    int                        ar_wait;
    int                        gap;

    function automatic logic [31:0] half_at(input logic [addr_w-1:0] addr);
        logic [31:0] x;
        x = addr[31:0] ^ 32'h1357_9bdf;
        return {x[26:0], x[31:27]};
    endfunction

    function automatic axi_r_t beat_for(input logic [addr_w-1:line_lsb] l,
                                        input logic [2:0] w, input logic last);
        axi_r_t b;
        b      = '0;
        b.id   = axi_id;
        b.data = {half_at({l, w, 3'b100}), half_at({l, w, 3'b000})};
        b.resp = 2'b00;
        b.last = last;
        return b;
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got == want) else begin
            $display("[ERROR] %s = %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    always @(posedge clk) begin : slave
        int delay;
        if (reset) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            r          <= '0;
            busy       <= 1'b0;
            prev_known <= 1'b0;
            ar_wait    <= $urandom % 6;
            gap        <= 0;
            errors     = 0;
            bursts     = 0;
            beats      = 0;
        end else begin
            // cache idle and missing: this is the address it latches
            if (!arvalid && !rready && !fetch_valid) begin
                miss_addr <= fetch_pc;
            end

            if (arvalid && arready) begin
                check_field("m_axi_ar.addr", ar.addr, miss_addr);
                check_field("m_axi_ar.len", 64'(ar.len), 64'd7);
                check_field("m_axi_ar.size", 64'(ar.size), 64'd3);
                check_field("m_axi_ar.burst", 64'(ar.burst), 64'd2);
                check_field("m_axi_ar.lock", 64'(ar.lock), 64'd0);
                check_field("m_axi_ar.cache", 64'(ar.cache), 64'd0);
                check_field("m_axi_ar.prot", 64'(ar.prot), 64'd6);
                check_field("m_axi_ar.id", 64'(ar.id), 64'(axi_id));
                assert (!prev_known || ar.addr[addr_w-1:line_lsb] != prev_line) else begin
                    $display("refill requested again for the line that was just loaded");
                    errors++;
                end
                bursts++;
                prev_line  <= ar.addr[addr_w-1:line_lsb];
                prev_known <= 1'b1;
                arready    <= 1'b0;
                busy       <= 1'b1;
                burst_line <= ar.addr[addr_w-1:line_lsb];
                offset     <= ar.addr[line_lsb-1:word_bytes_log];
                beat       <= 3'd0;
                ar_wait    <= $urandom % 6;
                delay = $urandom % 6;
                if (delay == 0) begin
                    rvalid <= 1'b1;
                    r      <= beat_for(ar.addr[addr_w-1:line_lsb],
                                       ar.addr[line_lsb-1:word_bytes_log], 1'b0);
                end else begin
                    gap <= delay;
                end
            end else if (arvalid && !busy) begin
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end

            if (busy) begin
                if (rvalid && rready) begin
                    beats++;
                    if (r.last) begin
                        busy   <= 1'b0;
                        rvalid <= 1'b0;
                    end else begin
                        delay = $urandom % 6;
                        beat <= beat + 3'd1;
                        if (delay == 0) begin
                            r <= beat_for(burst_line, offset + beat + 3'd1, beat == 3'd6);
                        end else begin
                            rvalid <= 1'b0;
                            gap    <= delay;
                        end
                    end
                end else if (!rvalid) begin
                    if (gap <= 1) begin
                        rvalid <= 1'b1;
                        r      <= beat_for(burst_line, offset + beat, beat == 3'd7);
                    end else begin
                        gap <= gap - 1;   // rvalid gap
                    end
                end
            end
        end
    end

endmodule

// ==== tests/fetch_tb.sv ====
module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    localparam logic [addr_w-1:0] start_pc = 64'h1000;
    localparam logic [id_w-1:0]   bus_id   = 13'd5;

    logic              clk;
    logic              reset;
    logic              stall;
    logic              redirect;
    logic [addr_w-1:0] redirect_pc;
    logic [31:0]       instr;
    logic [addr_w-1:0] instr_pc;
    logic              instr_valid;
    axi_ar_t           m_axi_ar;
    logic              m_axi_arvalid;
    logic              m_axi_arready;
    axi_r_t            m_axi_r;
    logic              m_axi_rvalid;
    logic              m_axi_rready;

    int                model_errors;
    int                bursts;
    int                beats;
    int                check_errors;   // comparing process
    int                seq_errors;     // stimulus process
    int                accepted;
    bit                timed_out;
    logic [addr_w-1:0] expect_pc;
    logic              held_valid;
    logic [addr_w-1:0] held_pc;
    logic [31:0]       held_instr;

    fetch_top #(
        .reset_pc (start_pc),
        .axi_id   (bus_id)
    ) fetch_top_i (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .instr_valid   (instr_valid),
        .m_axi_ar      (m_axi_ar),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_arready (m_axi_arready),
        .m_axi_r       (m_axi_r),
        .m_axi_rvalid  (m_axi_rvalid),
        .m_axi_rready  (m_axi_rready)
    );

    axi_rom_model #(
        .axi_id (bus_id)
    ) rom_i (
        .clk         (clk),
        .reset       (reset),
        .ar          (m_axi_ar),
        .arvalid     (m_axi_arvalid),
        .arready     (m_axi_arready),
        .r           (m_axi_r),
        .rvalid      (m_axi_rvalid),
        .rready      (m_axi_rready),
        .fetch_valid (instr_valid),
        .fetch_pc    (instr_pc),
        .errors      (model_errors),
        .bursts      (bursts),
        .beats       (beats)
    );

    // instruction stored at a byte address
    function automatic logic [31:0] instr_of(input logic [addr_w-1:0] addr);
        logic [31:0] x;
        x = addr[31:0] ^ 32'h1357_9bdf;
        return {x[26:0], x[31:27]};
    endfunction

    // word inside a line but not its first
    function automatic logic [addr_w-1:0] random_target();
        return 64'h2000 + 64'($urandom % 64) * 64'd64 + 64'(1 + $urandom % 15) * 64'd4;
    endfunction

    function automatic int total_errors();
        return check_errors + seq_errors + model_errors;
    endfunction

    task automatic note_timeout(input string what, input int limit);
        timed_out = 1'b1;
        seq_errors++;
        $display("timeout waiting for %s after %0d cycles", what, limit);
    endtask

    task automatic wait_accepts(input int target, input int limit, input string what);
        int i;
        if (timed_out) return;
        for (i = 0; i < limit; i++) begin
            @(negedge clk);
            if (accepted >= target) return;
        end
        note_timeout(what, limit);
    endtask

    task automatic wait_refill(input int limit);
        int i;
        if (timed_out) return;
        for (i = 0; i < limit; i++) begin
            @(negedge clk);
            if (m_axi_rready) return;
        end
        note_timeout("a refill burst", limit);
    endtask

    task automatic wait_bus_idle(input int limit);
        int i;
        if (timed_out) return;
        for (i = 0; i < limit; i++) begin
            @(negedge clk);
            if (!m_axi_arvalid && !m_axi_rready) return;
        end
        note_timeout("an idle AXI bus", limit);
    endtask

    task automatic check_idle_outputs();
        assert (!m_axi_arvalid) else begin
            $display("[ERROR] m_axi_arvalid = %h, expected 0", m_axi_arvalid);
            seq_errors++;
        end
        assert (!m_axi_rready) else begin
            $display("[ERROR] m_axi_rready = %h, expected 0", m_axi_rready);
            seq_errors++;
        end
        assert (!instr_valid) else begin
            $display("[ERROR] instr_valid = %h, expected 0", instr_valid);
            seq_errors++;
        end
        assert (instr_pc == start_pc) else begin
            $display("[ERROR] instr_pc = %h, expected %h", instr_pc, start_pc);
            seq_errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int mark);
        $display("test %0d %s: %0d errors", num, name, total_errors() - mark);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // compare each instruction the consumer accepts
    always @(posedge clk) begin : compare
        if (reset) begin
            expect_pc  = start_pc;
            held_valid = 1'b0;
        end else begin
            if (instr_valid && !stall) begin
                assert (instr_pc == expect_pc) else begin
                    $display("[ERROR] instr_pc = %h, expected %h", instr_pc, expect_pc);
                    check_errors++;
                end
                assert (instr == instr_of(instr_pc)) else begin
                    $display("[ERROR] instr = %h, expected %h at instr_pc %h",
                             instr, instr_of(instr_pc), instr_pc);
                    check_errors++;
                end
                accepted++;
                expect_pc = expect_pc + 64'd4;
            end
            if (instr_valid && stall) begin
                if (held_valid) begin
                    assert (instr_pc == held_pc && instr == held_instr) else begin
                        $display("[ERROR] instr_pc/instr = %h/%h, expected %h/%h while stalled",
                                 instr_pc, instr, held_pc, held_instr);
                        check_errors++;
                    end
                end
                held_valid = !redirect;
                held_pc    = instr_pc;
                held_instr = instr;
            end else begin
                held_valid = 1'b0;
            end
            if (redirect) begin
                expect_pc = redirect_pc;   // next accepted address
            end
        end
    end

    initial begin
        int i;
        int n;
        int mark;
        reset       = 1'b1;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        void'($urandom(17618));

        mark = total_errors();
        for (i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) reset <= 1'b0;
            @(negedge clk);
            check_idle_outputs();
        end
        report_test(1, "reset state", mark);

        mark = total_errors();
        wait_accepts(80, 3000, "sequential fetch across lines");
        report_test(2, "sequential fetch", mark);

        // 80 words from 0x1000 span five lines
        mark = total_errors();
        assert (bursts == 5) else begin
            $display("[ERROR] bursts = %h, expected %h", bursts, 5);
            seq_errors++;
        end
        report_test(3, "refill requests", mark);

        mark = total_errors();
        for (i = 0; i < 12; i++) begin
            if (i % 2 == 1) begin
                wait_refill(1000);   // redirect in the middle of a burst
            end else begin
                repeat ($urandom % 12) @(posedge clk);
            end
            @(posedge clk);
            redirect    <= 1'b1;
            redirect_pc <= random_target();
            @(posedge clk);
            redirect <= 1'b0;
            @(negedge clk);
            n = accepted;
            wait_accepts(n + 3, 1000, "fetch after redirect");
        end
        report_test(4, "redirect", mark);

        mark = total_errors();
        for (i = 0; i < 8; i++) begin
            repeat ($urandom % 6) @(posedge clk);
            @(posedge clk);
            stall <= 1'b1;
            repeat (1 + $urandom % 8) @(posedge clk);
            stall <= 1'b0;
            @(negedge clk);
            n = accepted;
            wait_accepts(n + 2, 1000, "fetch after stall");
        end
        report_test(5, "stall", mark);

        mark = total_errors();
        @(negedge clk);
        n = accepted;
        wait_accepts(n + 120, 5000, "fetch under back-pressure");
        wait_bus_idle(500);
        assert (beats == 8 * bursts) else begin
            $display("[ERROR] beats = %h, expected %h", beats, 8 * bursts);
            seq_errors++;
        end
        report_test(6, "back-pressure", mark);

        $display("6 tests, %0d instructions checked, %0d refills, %0d errors",
                 accepted, bursts, total_errors());
        if (total_errors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verilog/fetch_pc.sv ====
module fetch_pc #(
    parameter logic [fetch_pkg::addr_w-1:0] reset_pc = '0
) (
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         stall,
    input  logic                         redirect,      // single-cycle pulse
    input  logic [fetch_pkg::addr_w-1:0] redirect_pc,
    input  logic                         hit,

    output logic [fetch_pkg::addr_w-1:0] pc
);
    import fetch_pkg::*;

    logic [addr_w-1:0] next_pc;
    logic              advance;

    // current instruction was taken by the pipeline
    assign advance = hit && !stall;

    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;        // redirect wins over everything
        end else if (advance) begin
            next_pc = pc + addr_w'(4);
        end else begin
            next_pc = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= next_pc;
        end
    end

    // fetch addresses stay word aligned, including redirect targets
    pc_aligned_a: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    ) else $error("misaligned fetch address %h", pc);

endmodule

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    localparam int addr_w         = 64;
    localparam int data_w         = 64;
    localparam int id_w           = 13;
    localparam int line_words     = 8;   // 64-bit words per line
    localparam int word_bytes_log = 3;
    localparam int line_words_log = 3;

    localparam logic [1:0] burst_wrap   = 2'd2;
    localparam logic [2:0] prot_default = 3'd6;  // instruction, non-secure, unprivileged

    // read address channel payload
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;    // beats minus one
        logic [2:0]        size;   // log2 bytes per beat
        logic [1:0]        burst;
        logic              lock;
        logic [3:0]        cache;
        logic [2:0]        prot;
    } axi_ar_t;

    // read data channel payload
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    // refill sequencer states
    typedef enum logic [1:0] {
        cs_idle = 2'd0,
        cs_addr = 2'd1,
        cs_data = 2'd2
    } cache_state_e;

endpackage

// ==== verilog/fetch_top.sv ====
module fetch_top #(
    parameter logic [fetch_pkg::addr_w-1:0] reset_pc = '0,
    parameter logic [fetch_pkg::id_w-1:0]   axi_id   = '0
) (
    input  logic                         clk,
    input  logic                         reset,

    // pipeline side
    input  logic                         stall,
    input  logic                         redirect,
    input  logic [fetch_pkg::addr_w-1:0] redirect_pc,
    output logic [31:0]                  instr,
    output logic [fetch_pkg::addr_w-1:0] instr_pc,
    output logic                         instr_valid,

    // AXI read master
    output fetch_pkg::axi_ar_t           m_axi_ar,
    output logic                         m_axi_arvalid,
    input  logic                         m_axi_arready,
    input  fetch_pkg::axi_r_t            m_axi_r,
    input  logic                         m_axi_rvalid,
    output logic                         m_axi_rready
);
    import fetch_pkg::*;

    logic [addr_w-1:0] pc;
    logic              hit;

    fetch_pc #(
        .reset_pc   (reset_pc)
    ) fetch_pc_i (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .hit         (hit),
        .pc          (pc)
    );

    icache #(
        .axi_id     (axi_id)
    ) icache_i (
        .clk           (clk),
        .reset         (reset),
        .pc            (pc),
        .instr         (instr),
        .hit           (hit),
        .m_axi_ar      (m_axi_ar),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_arready (m_axi_arready),
        .m_axi_r       (m_axi_r),
        .m_axi_rvalid  (m_axi_rvalid),
        .m_axi_rready  (m_axi_rready)
    );

    assign instr_pc    = pc;
    assign instr_valid = hit;   // a hit is a valid instruction

endmodule

// ==== verilog/icache.sv ====
module icache #(
    parameter logic [fetch_pkg::id_w-1:0] axi_id = '0
) (
    input  logic                         clk,
    input  logic                         reset,

    input  logic [fetch_pkg::addr_w-1:0] pc,
    output logic [31:0]                  instr,
    output logic                         hit,

    output fetch_pkg::axi_ar_t           m_axi_ar,
    output logic                         m_axi_arvalid,
    input  logic                         m_axi_arready,
    input  fetch_pkg::axi_r_t            m_axi_r,
    input  logic                         m_axi_rvalid,
    output logic                         m_axi_rready
);
    import fetch_pkg::*;

    localparam int tag_lsb = line_words_log + word_bytes_log;  // first bit above the line

    logic [data_w-1:0]         mem [line_words];
    logic [addr_w-1:tag_lsb]   line_tag;
    logic                      line_valid;
    cache_state_e              state;
    logic [line_words_log-1:0] offset;      // next word slot to fill
    logic [addr_w-1:0]         ar_addr;     // address of the missed instruction
    logic [data_w-1:0]         word;
    logic                      ar_fire;
    logic                      r_fire;

    // read side, purely combinational
    assign word  = mem[pc[tag_lsb-1:word_bytes_log]];
    assign instr = pc[word_bytes_log-1] ? word[data_w-1:data_w/2] : word[data_w/2-1:0];
    assign hit   = line_valid && (pc[addr_w-1:tag_lsb] == line_tag);

    assign m_axi_arvalid = (state == cs_addr);
    assign m_axi_rready  = (state == cs_data);
    assign ar_fire       = m_axi_arvalid && m_axi_arready;
    assign r_fire        = m_axi_rvalid && m_axi_rready;

    // one wrapping burst covers the whole line, critical word first
    always_comb begin
        m_axi_ar       = '0;
        m_axi_ar.id    = axi_id;
        m_axi_ar.addr  = ar_addr;
        m_axi_ar.len   = 8'(line_words - 1);
        m_axi_ar.size  = 3'(word_bytes_log);
        m_axi_ar.burst = burst_wrap;
        m_axi_ar.lock  = 1'b0;
        m_axi_ar.cache = 4'h0;     // non-bufferable, non-cacheable
        m_axi_ar.prot  = prot_default;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= cs_idle;
            line_valid <= 1'b0;
        end else begin
            case (state)
                cs_idle: begin
                    if (!hit) begin
                        state <= cs_addr;
                    end
                end
                cs_addr: begin
                    if (m_axi_arready) begin
                        state      <= cs_data;
                        line_valid <= 1'b0;    // old contents are about to be overwritten
                    end
                end
                cs_data: begin
                    if (m_axi_rvalid && m_axi_r.last) begin
                        state      <= cs_idle;
                        line_valid <= 1'b1;
                    end
                end
                default: state <= cs_idle;
            endcase
        end
    end

    // payload: request address, tag and line storage
    always_ff @(posedge clk) begin
        if (state == cs_idle && !hit) begin
            ar_addr <= pc;
        end
        if (ar_fire) begin
            line_tag <= ar_addr[addr_w-1:tag_lsb];
            offset   <= ar_addr[tag_lsb-1:word_bytes_log];  // start at the missed word
        end
        if (r_fire) begin
            mem[offset] <= m_axi_r.data;
            offset      <= offset + 1'b1;     // wraps modulo line size
        end
    end

    // request must not change while the slave holds off arready
    ar_stable_a: assert property (
        @(posedge clk) disable iff (reset)
        m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_ar)
    ) else $error("ar payload changed while waiting for arready");

    // slave must only present read data for an accepted burst
    r_in_burst_a: assert property (
        @(posedge clk) disable iff (reset)
        m_axi_rvalid |-> state == cs_data
    ) else $error("rvalid outside of a refill burst");

endmodule
